// File: Makefile
VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/ex_stage_chk.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_chk (
    input logic              clk,
    input logic              rst_n,
    input logic              branch_valid,
    input logic              pc_src,
    input ex_pkg::reg_addr_t rd,
    input ex_pkg::reg_addr_t ex_mem_rd,
    input logic              ex_mem_mem_write,
    input logic              ex_mem_reg_write
);

    // Marks that $past has a previous edge to look at
    logic started = 1'b0;

    always @(posedge clk) begin
        started <= 1'b1;
    end

    a_redirect_needs_valid: assert property (@(posedge clk) pc_src |-> branch_valid)
        else $error("pc_src high while branch_valid is low");

    a_no_write_after_reset: assert property (@(posedge clk)
        started && !$past(rst_n) |-> !ex_mem_mem_write && !ex_mem_reg_write)
        else $error("EX/MEM write enable set in the cycle after reset");

    a_rd_follows_input: assert property (@(posedge clk)
        started && $past(rst_n) |-> ex_mem_rd == $past(rd))
        else $error("ex_mem_rd does not match rd of the previous cycle");

endmodule

bind ex_stage_top ex_stage_chk u_chk (
    .clk              (clk),
    .rst_n            (rst_n),
    .branch_valid     (branch_valid),
    .pc_src           (pc_src),
    .rd               (rd),
    .ex_mem_rd        (ex_mem_rd),
    .ex_mem_mem_write (ex_mem_mem_write),
    .ex_mem_reg_write (ex_mem_reg_write)
);

`default_nettype wire

// File: bench/ex_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb;
    import ex_pkg::*;

    localparam int NUM_INSTR      = 2000;
    localparam int TIMEOUT_CYCLES = NUM_INSTR + 100;
    localparam logic [31:0] SEED  = 32'h83f3_da2d;

    typedef struct packed {
        data_t       alu_result;
        data_t       write_data;
        pc_t         pc_plus4;
        reg_addr_t   rd;
        result_src_t result_src;
        logic        mem_write;
        logic        reg_write;
    } exp_t;

    logic clk;
    logic rst_n;
    data_t rs1_data, rs2_data, imm, mem_result, wb_result;
    pc_t pc, pc_plus4, branch_target, ex_mem_pc_plus4;
    reg_addr_t rs1, rs2, rd, mem_rd, wb_rd, ex_mem_rd;
    alu_ctrl_t alu_ctrl;
    branch_ctrl_t branch_ctrl;
    alu_src_t alu_src;
    result_src_t result_src, ex_mem_result_src;
    logic branch_valid, mem_write, reg_write, mem_reg_write, wb_reg_write;
    logic pc_src, ex_mem_mem_write, ex_mem_reg_write;
    data_t ex_mem_alu_result, ex_mem_write_data;

    logic [31:0] lfsr_state;
    exp_t        exp_q[$];
    int          alu_hits [64];
    int          check_count = 0;
    int          error_count = 0;
    int          cycle_count = 0;

    ex_stage_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED: %s actual=0x%08h expected=0x%08h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    // Newest nonzero writer first, then WB, then the register file
    function automatic data_t forward_value(input reg_addr_t src, input data_t rf_value);
        if (src != 5'd0 && mem_reg_write && mem_rd == src) begin
            return mem_result;
        end
        if (src != 5'd0 && wb_reg_write && wb_rd == src) begin
            return wb_result;
        end
        return rf_value;
    endfunction

    function automatic data_t model_alu(input alu_ctrl_t op, input data_t a, input data_t b);
        logic [4:0] sh;
        data_t      res;
        sh = b[4:0];
        case (op)
            ALU_ADD:   res = a + b;
            ALU_SUB:   res = a + ~b + 32'd1;
            ALU_AND:   res = a & b;
            ALU_OR:    res = a | b;
            ALU_XOR:   res = a ^ b;
            ALU_SLL:   res = a << sh;
            ALU_SRL:   res = a >> sh;
            ALU_SRA: begin
                res = a >> sh;
                if (a[31]) begin
                    res = res | ~(32'hffff_ffff >> sh);
                end
            end
            ALU_SLT:   res = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            ALU_SLTU:  res = (a < b) ? 32'd1 : 32'd0;
            ALU_PASSB: res = b;
            default:   res = '0;
        endcase
        return res;
    endfunction

    function automatic logic branch_taken(input branch_ctrl_t code, input data_t a,
                                          input data_t b);
        logic lt_s;
        logic lt_u;
        lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
        lt_u = a < b;
        case (code)
            BR_EQ:   return a == b;
            BR_NE:   return a != b;
            BR_LT:   return lt_s;
            BR_GE:   return !lt_s;
            BR_LTU:  return lt_u;
            BR_GEU:  return !lt_u;
            default: return 1'b1;
        endcase
    endfunction

    task automatic drive_random_instr();
        logic [31:0] r;
        data_t       a_data;
        pc_t         pc_v;
        a_data = rand_bits(32);
        rs1_data <= a_data;
        // Equal operands now and then so BEQ/BGE get taken
        r = rand_bits(2);
        rs2_data <= (r == 32'd0) ? a_data : rand_bits(32);
        r = rand_bits(12);
        imm <= {{20{r[11]}}, r[11:0]};
        r = rand_bits(30);
        pc_v = {r[29:0], 2'b00};
        pc <= pc_v;
        pc_plus4 <= pc_v + 32'd4;
        rs1 <= {2'b00, 3'(rand_bits(3))};
        rs2 <= {2'b00, 3'(rand_bits(3))};
        rd <= 5'(rand_bits(5));
        r = rand_bits(4) % 11;
        alu_ctrl <= r[3:0];
        branch_ctrl <= 3'(rand_bits(3));
        branch_valid <= 1'(rand_bits(1));
        alu_src <= 2'(rand_bits(2));
        result_src <= 2'(rand_bits(2));
        mem_write <= 1'(rand_bits(1));
        reg_write <= 1'(rand_bits(1));
        mem_rd <= {2'b00, 3'(rand_bits(3))};
        mem_reg_write <= 1'(rand_bits(1));
        mem_result <= rand_bits(32);
        wb_rd <= {2'b00, 3'(rand_bits(3))};
        wb_reg_write <= 1'(rand_bits(1));
        wb_result <= rand_bits(32);
    endtask

    // Redirect path checked now and EX/MEM expectation queued for the next cycle
    task automatic model_cycle();
        data_t fa, fb, in_a, in_b;
        pc_t   target;
        exp_t  e;
        fa = forward_value(rs1, rs1_data);
        fb = forward_value(rs2, rs2_data);
        in_a = alu_src[ALU_SRC_PC_BIT] ? pc : fa;
        in_b = alu_src[ALU_SRC_IMM_BIT] ? imm : fb;
        target = (branch_ctrl == BR_JALR) ? ((fa + imm) & ~32'd1) : (pc + imm);
        check_val("pc_src", 32'(pc_src), 32'(branch_valid & branch_taken(branch_ctrl, fa, fb)));
        check_val("branch_target", branch_target, target);
        e = '{model_alu(alu_ctrl, in_a, in_b), fb, pc_plus4, rd, result_src,
              mem_write, reg_write};
        exp_q.push_back(e);
        alu_hits[{alu_ctrl, alu_src}] = alu_hits[{alu_ctrl, alu_src}] + 1;
    endtask

    task automatic check_registered();
        exp_t e;
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            check_val("ex_mem_alu_result", ex_mem_alu_result, e.alu_result);
            check_val("ex_mem_write_data", ex_mem_write_data, e.write_data);
            check_val("ex_mem_pc_plus4", ex_mem_pc_plus4, e.pc_plus4);
            check_val("ex_mem_rd", 32'(ex_mem_rd), 32'(e.rd));
            check_val("ex_mem_result_src", 32'(ex_mem_result_src), 32'(e.result_src));
            check_val("ex_mem_mem_write", 32'(ex_mem_mem_write), 32'(e.mem_write));
            check_val("ex_mem_reg_write", 32'(ex_mem_reg_write), 32'(e.reg_write));
        end
    endtask

    task automatic check_reset_outputs();
        check_val("ex_mem_mem_write", 32'(ex_mem_mem_write), 32'd0);
        check_val("ex_mem_reg_write", 32'(ex_mem_reg_write), 32'd0);
        check_val("ex_mem_rd", 32'(ex_mem_rd), 32'd0);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run went past %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("Checks: %0d  Errors: %0d", check_count, error_count);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        lfsr_state = SEED;
        rst_n = 1'b0;
        {rs1_data, rs2_data, imm, pc, pc_plus4} = '0;
        {rs1, rs2, alu_ctrl, branch_ctrl, branch_valid, alu_src, result_src} = '0;
        {mem_rd, mem_reg_write, mem_result, wb_rd, wb_reg_write, wb_result} = '0;
        // Live write controls during reset must not reach EX/MEM
        rd = 5'h1f;
        mem_write = 1'b1;
        reg_write = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_reset_outputs();
        @(posedge clk);
        rst_n <= 1'b1;
        drive_random_instr();
        @(negedge clk);
        check_reset_outputs();
        model_cycle();
        for (int n = 1; n < NUM_INSTR; n++) begin
            @(posedge clk);
            drive_random_instr();
            @(negedge clk);
            check_registered();
            model_cycle();
        end
        @(posedge clk);
        @(negedge clk);
        check_registered();
        for (int k = 0; k < 44; k++) begin
            if (alu_hits[k[5:0]] == 0) begin
                error_count++;
                $display("ALU op %0d was never run with alu_src %0d", k / 4, k % 4);
            end
        end
        $display("Checks: %0d  Errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
rtl/ex_pkg.sv
rtl/ex_bus_if.sv
rtl/forward_unit.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/execute.sv
rtl/ex_mem_reg.sv
rtl/ex_stage_top.sv
bench/ex_stage_chk.sv
bench/ex_stage_tb.sv

// File: rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  ex_pkg::alu_ctrl_t alu_ctrl,
    input  ex_pkg::data_t     in_a,
    input  ex_pkg::data_t     in_b,
    output ex_pkg::data_t     result
);
    import ex_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = in_b[4:0];
    assign lt_signed   = $signed(in_a) < $signed(in_b);
    assign lt_unsigned = in_a < in_b;

    always_comb begin
        case (alu_ctrl)
            ALU_ADD: begin
                result = in_a + in_b;
            end
            ALU_SUB: begin
                result = in_a - in_b;
            end
            ALU_AND: begin
                result = in_a & in_b;
            end
            ALU_OR: begin
                result = in_a | in_b;
            end
            ALU_XOR: begin
                result = in_a ^ in_b;
            end
            ALU_SLL: begin
                result = in_a << shamt;
            end
            ALU_SRL: begin
                result = in_a >> shamt;
            end
            ALU_SRA: begin
                result = data_t'($signed(in_a) >>> shamt);
            end
            ALU_SLT: begin
                result = {{(DATA_W-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result = {{(DATA_W-1){1'b0}}, lt_unsigned};
            end
            // lui arrives with the immediate on operand two
            ALU_PASSB: begin
                result = in_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  ex_pkg::branch_ctrl_t branch_ctrl,
    input  logic                 branch_valid,
    input  ex_pkg::data_t        op_a,
    input  ex_pkg::data_t        op_b,
    input  ex_pkg::pc_t          pc,
    input  ex_pkg::data_t        imm,
    output logic                 pc_src,
    output ex_pkg::pc_t          branch_target
);
    import ex_pkg::*;

    logic  taken;
    data_t jalr_sum;

    always_comb begin
        case (branch_ctrl)
            BR_EQ:   taken = (op_a == op_b);
            BR_NE:   taken = (op_a != op_b);
            BR_LT:   taken = ($signed(op_a) < $signed(op_b));
            BR_GE:   taken = ($signed(op_a) >= $signed(op_b));
            BR_LTU:  taken = (op_a < op_b);
            BR_GEU:  taken = (op_a >= op_b);
            // jal and jalr
            default: taken = 1'b1;
        endcase
    end

    assign pc_src = branch_valid & taken;

    // jalr drops bit 0 of the register-relative sum
    assign jalr_sum = op_a + imm;

    always_comb begin
        if (branch_ctrl == BR_JALR) begin
            branch_target = {jalr_sum[PC_W-1:1], 1'b0};
        end else begin
            branch_target = pc + imm;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ex_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface id_ex_if;
    ex_pkg::data_t        rs1_data;
    ex_pkg::data_t        rs2_data;
    ex_pkg::data_t        imm;
    ex_pkg::pc_t          pc;
    ex_pkg::pc_t          pc_plus4;
    ex_pkg::reg_addr_t    rs1;
    ex_pkg::reg_addr_t    rs2;
    ex_pkg::reg_addr_t    rd;
    ex_pkg::alu_ctrl_t    alu_ctrl;
    ex_pkg::branch_ctrl_t branch_ctrl;
    logic                 branch_valid;
    ex_pkg::alu_src_t     alu_src;
    ex_pkg::result_src_t  result_src;
    logic                 mem_write;
    logic                 reg_write;

    modport source (output rs1_data, rs2_data, imm, pc, pc_plus4, rs1, rs2, rd,
                    alu_ctrl, branch_ctrl, branch_valid, alu_src, result_src,
                    mem_write, reg_write);
    modport sink   (input  rs1_data, rs2_data, imm, pc, pc_plus4, rs1, rs2, rd,
                    alu_ctrl, branch_ctrl, branch_valid, alu_src, result_src,
                    mem_write, reg_write);
endinterface

interface ex_mem_if;
    ex_pkg::data_t       alu_result;
    ex_pkg::data_t       write_data;
    ex_pkg::pc_t         pc_plus4;
    ex_pkg::reg_addr_t   rd;
    ex_pkg::result_src_t result_src;
    logic                mem_write;
    logic                reg_write;

    modport source (output alu_result, write_data, pc_plus4, rd, result_src,
                    mem_write, reg_write);
    modport sink   (input  alu_result, write_data, pc_plus4, rd, result_src,
                    mem_write, reg_write);
endinterface

`default_nettype wire

// File: rtl/ex_mem_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg (
    input  logic                clk,
    input  logic                rst_n,
    ex_mem_if.sink              ex,
    output ex_pkg::data_t       alu_result,
    output ex_pkg::data_t       write_data,
    output ex_pkg::pc_t         pc_plus4,
    output ex_pkg::reg_addr_t   rd,
    output ex_pkg::result_src_t result_src,
    output logic                mem_write,
    output logic                reg_write
);

    // Control fields, cleared so nothing gets written after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd        <= '0;
            mem_write <= 1'b0;
            reg_write <= 1'b0;
        end else begin
            rd        <= ex.rd;
            mem_write <= ex.mem_write;
            reg_write <= ex.reg_write;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        alu_result <= ex.alu_result;
        write_data <= ex.write_data;
        pc_plus4   <= ex.pc_plus4;
        result_src <= ex.result_src;
    end

endmodule

`default_nettype wire

// File: rtl/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int DATA_W     = 32;
    localparam int PC_W       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [PC_W-1:0]       pc_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [3:0]            alu_ctrl_t;
    typedef logic [2:0]            branch_ctrl_t;
    typedef logic [1:0]            alu_src_t;
    typedef logic [1:0]            result_src_t;
    typedef logic [1:0]            fwd_sel_t;

    // ALU operations
    localparam alu_ctrl_t ALU_ADD   = 4'd0;
    localparam alu_ctrl_t ALU_SUB   = 4'd1;
    localparam alu_ctrl_t ALU_AND   = 4'd2;
    localparam alu_ctrl_t ALU_OR    = 4'd3;
    localparam alu_ctrl_t ALU_XOR   = 4'd4;
    localparam alu_ctrl_t ALU_SLL   = 4'd5;
    localparam alu_ctrl_t ALU_SRL   = 4'd6;
    localparam alu_ctrl_t ALU_SRA   = 4'd7;
    localparam alu_ctrl_t ALU_SLT   = 4'd8;
    localparam alu_ctrl_t ALU_SLTU  = 4'd9;
    localparam alu_ctrl_t ALU_PASSB = 4'd10;

    // Branch conditions follow funct3, jumps fill the gaps
    localparam branch_ctrl_t BR_EQ   = 3'b000;
    localparam branch_ctrl_t BR_NE   = 3'b001;
    localparam branch_ctrl_t BR_JAL  = 3'b010;
    localparam branch_ctrl_t BR_JALR = 3'b011;
    localparam branch_ctrl_t BR_LT   = 3'b100;
    localparam branch_ctrl_t BR_GE   = 3'b101;
    localparam branch_ctrl_t BR_LTU  = 3'b110;
    localparam branch_ctrl_t BR_GEU  = 3'b111;

    // Operand select bits
    localparam int ALU_SRC_IMM_BIT = 0;
    localparam int ALU_SRC_PC_BIT  = 1;

    // Bypass sources
    localparam fwd_sel_t FWD_RF  = 2'd0;
    localparam fwd_sel_t FWD_MEM = 2'd1;
    localparam fwd_sel_t FWD_WB  = 2'd2;

endpackage

`default_nettype wire

// File: rtl/ex_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ex_pkg::data_t        rs1_data,
    input  ex_pkg::data_t        rs2_data,
    input  ex_pkg::data_t        imm,
    input  ex_pkg::pc_t          pc,
    input  ex_pkg::pc_t          pc_plus4,
    input  ex_pkg::reg_addr_t    rs1,
    input  ex_pkg::reg_addr_t    rs2,
    input  ex_pkg::reg_addr_t    rd,
    input  ex_pkg::alu_ctrl_t    alu_ctrl,
    input  ex_pkg::branch_ctrl_t branch_ctrl,
    input  logic                 branch_valid,
    input  ex_pkg::alu_src_t     alu_src,
    input  ex_pkg::result_src_t  result_src,
    input  logic                 mem_write,
    input  logic                 reg_write,
    input  ex_pkg::reg_addr_t    mem_rd,
    input  logic                 mem_reg_write,
    input  ex_pkg::data_t        mem_result,
    input  ex_pkg::reg_addr_t    wb_rd,
    input  logic                 wb_reg_write,
    input  ex_pkg::data_t        wb_result,
    output logic                 pc_src,
    output ex_pkg::pc_t          branch_target,
    output ex_pkg::data_t        ex_mem_alu_result,
    output ex_pkg::data_t        ex_mem_write_data,
    output ex_pkg::pc_t          ex_mem_pc_plus4,
    output ex_pkg::reg_addr_t    ex_mem_rd,
    output ex_pkg::result_src_t  ex_mem_result_src,
    output logic                 ex_mem_mem_write,
    output logic                 ex_mem_reg_write
);

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    assign id_ex.rs1_data     = rs1_data;
    assign id_ex.rs2_data     = rs2_data;
    assign id_ex.imm          = imm;
    assign id_ex.pc           = pc;
    assign id_ex.pc_plus4     = pc_plus4;
    assign id_ex.rs1          = rs1;
    assign id_ex.rs2          = rs2;
    assign id_ex.rd           = rd;
    assign id_ex.alu_ctrl     = alu_ctrl;
    assign id_ex.branch_ctrl  = branch_ctrl;
    assign id_ex.branch_valid = branch_valid;
    assign id_ex.alu_src      = alu_src;
    assign id_ex.result_src   = result_src;
    assign id_ex.mem_write    = mem_write;
    assign id_ex.reg_write    = reg_write;

    execute u_execute (
        .id            (id_ex.sink),
        .mem_rd        (mem_rd),
        .mem_reg_write (mem_reg_write),
        .mem_result    (mem_result),
        .wb_rd         (wb_rd),
        .wb_reg_write  (wb_reg_write),
        .wb_result     (wb_result),
        .pc_src        (pc_src),
        .branch_target (branch_target),
        .ex_mem        (ex_mem.source)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex         (ex_mem.sink),
        .alu_result (ex_mem_alu_result),
        .write_data (ex_mem_write_data),
        .pc_plus4   (ex_mem_pc_plus4),
        .rd         (ex_mem_rd),
        .result_src (ex_mem_result_src),
        .mem_write  (ex_mem_mem_write),
        .reg_write  (ex_mem_reg_write)
    );

endmodule

`default_nettype wire

// File: rtl/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
    id_ex_if.sink             id,
    input  ex_pkg::reg_addr_t mem_rd,
    input  logic              mem_reg_write,
    input  ex_pkg::data_t     mem_result,
    input  ex_pkg::reg_addr_t wb_rd,
    input  logic              wb_reg_write,
    input  ex_pkg::data_t     wb_result,
    output logic              pc_src,
    output ex_pkg::pc_t       branch_target,
    ex_mem_if.source          ex_mem
);
    import ex_pkg::*;

    data_t op_a;
    data_t op_b;
    data_t alu_in_a;
    data_t alu_in_b;
    data_t alu_out;

    forward_unit u_forward (
        .rs1           (id.rs1),
        .rs2           (id.rs2),
        .rs1_data      (id.rs1_data),
        .rs2_data      (id.rs2_data),
        .mem_rd        (mem_rd),
        .mem_reg_write (mem_reg_write),
        .mem_result    (mem_result),
        .wb_rd         (wb_rd),
        .wb_reg_write  (wb_reg_write),
        .wb_result     (wb_result),
        .op_a          (op_a),
        .op_b          (op_b)
    );

    // auipc and jal take the PC, immediates replace operand two
    assign alu_in_a = id.alu_src[ALU_SRC_PC_BIT]  ? id.pc  : op_a;
    assign alu_in_b = id.alu_src[ALU_SRC_IMM_BIT] ? id.imm : op_b;

    alu u_alu (
        .alu_ctrl (id.alu_ctrl),
        .in_a     (alu_in_a),
        .in_b     (alu_in_b),
        .result   (alu_out)
    );

    branch_unit u_branch (
        .branch_ctrl   (id.branch_ctrl),
        .branch_valid  (id.branch_valid),
        .op_a          (op_a),
        .op_b          (op_b),
        .pc            (id.pc),
        .imm           (id.imm),
        .pc_src        (pc_src),
        .branch_target (branch_target)
    );

    assign ex_mem.alu_result = alu_out;
    // Store data is the bypassed rs2 value
    assign ex_mem.write_data = op_b;
    assign ex_mem.pc_plus4   = id.pc_plus4;
    assign ex_mem.rd         = id.rd;
    assign ex_mem.result_src = id.result_src;
    assign ex_mem.mem_write  = id.mem_write;
    assign ex_mem.reg_write  = id.reg_write;

endmodule

`default_nettype wire

// File: rtl/forward_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forward_unit (
    input  ex_pkg::reg_addr_t rs1,
    input  ex_pkg::reg_addr_t rs2,
    input  ex_pkg::data_t     rs1_data,
    input  ex_pkg::data_t     rs2_data,
    input  ex_pkg::reg_addr_t mem_rd,
    input  logic              mem_reg_write,
    input  ex_pkg::data_t     mem_result,
    input  ex_pkg::reg_addr_t wb_rd,
    input  logic              wb_reg_write,
    input  ex_pkg::data_t     wb_result,
    output ex_pkg::data_t     op_a,
    output ex_pkg::data_t     op_b
);
    import ex_pkg::*;

    fwd_sel_t sel_a;
    fwd_sel_t sel_b;

    // Newest writer of a nonzero register wins
    function automatic fwd_sel_t pick_source(input reg_addr_t rs);
        if (mem_reg_write && (mem_rd != '0) && (mem_rd == rs)) begin
            return FWD_MEM;
        end else if (wb_reg_write && (wb_rd != '0) && (wb_rd == rs)) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    function automatic data_t bypass(input fwd_sel_t sel, input data_t rf_value);
        case (sel)
            FWD_MEM: return mem_result;
            FWD_WB:  return wb_result;
            default: return rf_value;
        endcase
    endfunction

    assign sel_a = pick_source(rs1);
    assign sel_b = pick_source(rs2);

    assign op_a = bypass(sel_a, rs1_data);
    assign op_b = bypass(sel_b, rs2_data);

endmodule

`default_nettype wire
